//--- logic/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data word width
`define CPU_XLEN 32

// general registers
`define CPU_REG_COUNT 32

// register number width
`define CPU_REG_ADDR_W 5

`endif

//--- logic/isa_pkg.sv
`default_nettype none

`include "cpu_macros.svh"

package isa_pkg;

    // major opcodes of the supported instructions
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    // R-type function field
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic {
        SRC_B_RT  = 1'b0,
        SRC_B_IMM = 1'b1
    } src_b_e;

    typedef struct packed {
        alu_op_e                    alu_op;
        src_b_e                     src_b;
        logic                       use_shamt;
        logic [`CPU_XLEN-1:0]       imm;
        logic                       wen;
        logic [`CPU_REG_ADDR_W-1:0] dest;
    } decoded_t;

endpackage

`default_nettype wire

//--- logic/pipe_pkg.sv
`default_nettype none

`include "cpu_macros.svh"

package pipe_pkg;

    // IF/ID payload
    typedef struct packed {
        logic [`CPU_XLEN-1:0] instr;
    } fetch_t;

    // ID/EX payload, operands already forwarded
    typedef struct packed {
        isa_pkg::decoded_t          dec;
        logic [`CPU_XLEN-1:0]       rs_data;
        logic [`CPU_XLEN-1:0]       rt_data;
        logic [`CPU_REG_ADDR_W-1:0] shamt;
    } exec_t;

    // EX/WB payload and trace item
    typedef struct packed {
        logic                       wen;
        logic [`CPU_REG_ADDR_W-1:0] waddr;
        logic [`CPU_XLEN-1:0]       wdata;
    } retire_t;

endpackage

`default_nettype wire

//--- logic/pipeline_reg.sv
`timescale 1ns/100ps
`default_nettype none

module pipeline_reg #(
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     valid_in,
    input  wire logic     allow_out,
    input  wire payload_t data_in,
    output logic          allow_in,
    output logic          valid_out,
    output payload_t      data_out
);

    logic     valid_q;
    payload_t data_q;

    // empty, or the held item moves on this edge
    assign allow_in  = !valid_q || allow_out;
    assign valid_out = valid_q;
    assign data_out  = data_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (allow_in) begin
            valid_q <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (allow_in && valid_in) begin
            data_q <= data_in;
        end
    end

    // held item must not change under back-pressure
    a_hold_stable: assert property (@(posedge clk) disable iff (reset)
        valid_out && !allow_out |=> valid_out && $stable(data_out));

endmodule

`default_nettype wire

//--- logic/decode_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_macros.svh"

module decode_unit (
    input  wire logic [`CPU_XLEN-1:0]       instr,
    output isa_pkg::decoded_t               decoded,
    output logic      [`CPU_REG_ADDR_W-1:0] rs_addr,
    output logic      [`CPU_REG_ADDR_W-1:0] rt_addr,
    output logic      [`CPU_REG_ADDR_W-1:0] shamt
);

    logic [5:0]                 opcode;
    logic [5:0]                 funct;
    logic [`CPU_REG_ADDR_W-1:0] rd_addr;
    logic [15:0]                imm16;

    assign opcode  = instr[31:26];
    assign rs_addr = instr[25:21];
    assign rt_addr = instr[20:16];
    assign rd_addr = instr[15:11];
    assign shamt   = instr[10:6];
    assign funct   = instr[5:0];
    assign imm16   = instr[15:0];

    always_comb begin
        logic                       known;
        logic                       dest_is_rt;
        logic                       sign_ext;
        logic [`CPU_REG_ADDR_W-1:0] dest;

        known              = 1'b1;
        dest_is_rt         = 1'b1;
        sign_ext           = 1'b0;
        decoded            = '0;
        decoded.alu_op     = isa_pkg::ALU_ADD;
        decoded.src_b      = isa_pkg::SRC_B_IMM;
        decoded.use_shamt  = 1'b0;

        case (opcode)
            isa_pkg::OP_SPECIAL: begin
                dest_is_rt    = 1'b0;
                decoded.src_b = isa_pkg::SRC_B_RT;
                case (funct)
                    isa_pkg::FN_ADDU: decoded.alu_op = isa_pkg::ALU_ADD;
                    isa_pkg::FN_SUBU: decoded.alu_op = isa_pkg::ALU_SUB;
                    isa_pkg::FN_AND:  decoded.alu_op = isa_pkg::ALU_AND;
                    isa_pkg::FN_OR:   decoded.alu_op = isa_pkg::ALU_OR;
                    isa_pkg::FN_XOR:  decoded.alu_op = isa_pkg::ALU_XOR;
                    isa_pkg::FN_NOR:  decoded.alu_op = isa_pkg::ALU_NOR;
                    isa_pkg::FN_SLT:  decoded.alu_op = isa_pkg::ALU_SLT;
                    isa_pkg::FN_SLTU: decoded.alu_op = isa_pkg::ALU_SLTU;
                    isa_pkg::FN_SLL: begin
                        decoded.alu_op    = isa_pkg::ALU_SLL;
                        decoded.use_shamt = 1'b1;
                    end
                    isa_pkg::FN_SRL: begin
                        decoded.alu_op    = isa_pkg::ALU_SRL;
                        decoded.use_shamt = 1'b1;
                    end
                    isa_pkg::FN_SRA: begin
                        decoded.alu_op    = isa_pkg::ALU_SRA;
                        decoded.use_shamt = 1'b1;
                    end
                    default: known = 1'b0;
                endcase
            end
            isa_pkg::OP_ADDIU: begin
                decoded.alu_op = isa_pkg::ALU_ADD;
                sign_ext       = 1'b1;
            end
            isa_pkg::OP_SLTI: begin
                decoded.alu_op = isa_pkg::ALU_SLT;
                sign_ext       = 1'b1;
            end
            isa_pkg::OP_SLTIU: begin
                // immediate is sign-extended, then compared unsigned
                decoded.alu_op = isa_pkg::ALU_SLTU;
                sign_ext       = 1'b1;
            end
            isa_pkg::OP_ANDI: decoded.alu_op = isa_pkg::ALU_AND;
            isa_pkg::OP_ORI:  decoded.alu_op = isa_pkg::ALU_OR;
            isa_pkg::OP_XORI: decoded.alu_op = isa_pkg::ALU_XOR;
            isa_pkg::OP_LUI:  decoded.alu_op = isa_pkg::ALU_LUI;
            default: known = 1'b0;
        endcase

        decoded.imm = sign_ext ? {{(`CPU_XLEN-16){imm16[15]}}, imm16}
                               : {{(`CPU_XLEN-16){1'b0}}, imm16};

        dest         = dest_is_rt ? rt_addr : rd_addr;
        decoded.dest = dest;
        // no write for unknown encodings or register 0
        decoded.wen  = known && (dest != '0);
    end

endmodule

`default_nettype wire

//--- logic/regfile.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_macros.svh"

module regfile (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic [`CPU_REG_ADDR_W-1:0] rs_addr,
    input  wire logic [`CPU_REG_ADDR_W-1:0] rt_addr,
    input  wire logic                       wen,
    input  wire logic [`CPU_REG_ADDR_W-1:0] waddr,
    input  wire logic [`CPU_XLEN-1:0]       wdata,
    output logic      [`CPU_XLEN-1:0]       rs_data,
    output logic      [`CPU_XLEN-1:0]       rt_data
);

    logic [`CPU_XLEN-1:0] regs [`CPU_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // register 0 is hard zero
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

    // decode already drops writes to register 0
    a_no_zero_write: assert property (@(posedge clk) disable iff (reset)
        !(wen && waddr == '0));

endmodule

`default_nettype wire

//--- logic/forward_select.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_macros.svh"

module forward_select (
    input  wire logic [`CPU_REG_ADDR_W-1:0] src_addr,
    input  wire logic [`CPU_XLEN-1:0]       rf_data,
    input  wire logic                       ex_valid,
    input  wire pipe_pkg::retire_t          ex_result,
    input  wire logic                       wb_valid,
    input  wire pipe_pkg::retire_t          wb_result,
    output logic      [`CPU_XLEN-1:0]       operand
);

    logic ex_hit;
    logic wb_hit;

    assign ex_hit = ex_valid && ex_result.wen && (ex_result.waddr == src_addr);
    assign wb_hit = wb_valid && wb_result.wen && (wb_result.waddr == src_addr);

    // youngest producer wins
    assign operand = ex_hit ? ex_result.wdata :
                     wb_hit ? wb_result.wdata :
                              rf_data;

    // zero comes from decode never flagging register 0 and from the register file
    always_comb begin
        a_zero_source: assert final (src_addr != '0 || operand == '0);
    end

endmodule

`default_nettype wire

//--- logic/alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_macros.svh"

module alu (
    input  wire isa_pkg::alu_op_e      op,
    input  wire logic [`CPU_XLEN-1:0]  a,
    input  wire logic [`CPU_XLEN-1:0]  b,
    output logic      [`CPU_XLEN-1:0]  result
);

    localparam int SHIFT_W = $clog2(`CPU_XLEN);
    localparam int HALF    = `CPU_XLEN / 2;

    logic [SHIFT_W-1:0] sa;

    assign sa = a[SHIFT_W-1:0];

    always_comb begin
        result = '0;
        case (op)
            // wraps, no overflow trap
            isa_pkg::ALU_ADD:  result = a + b;
            isa_pkg::ALU_SUB:  result = a - b;
            isa_pkg::ALU_AND:  result = a & b;
            isa_pkg::ALU_OR:   result = a | b;
            isa_pkg::ALU_XOR:  result = a ^ b;
            isa_pkg::ALU_NOR:  result = ~(a | b);
            isa_pkg::ALU_SLT:  result[0] = $signed(a) < $signed(b);
            isa_pkg::ALU_SLTU: result[0] = a < b;
            isa_pkg::ALU_SLL:  result = b << sa;
            isa_pkg::ALU_SRL:  result = b >> sa;
            isa_pkg::ALU_SRA:  result = $signed(b) >>> sa;
            isa_pkg::ALU_LUI:  result = {b[HALF-1:0], {HALF{1'b0}}};
            default:           result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/alu_pipeline_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_macros.svh"

module alu_pipeline_top (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 inst_valid,
    input  wire logic [`CPU_XLEN-1:0] inst_data,
    input  wire logic                 trace_ready,
    output logic                      inst_ready,
    output logic                      trace_valid,
    output pipe_pkg::retire_t         trace
);

    pipe_pkg::fetch_t           if_in;
    pipe_pkg::fetch_t           id_fetch;
    pipe_pkg::exec_t            id_exec;
    pipe_pkg::exec_t            ex_exec;
    pipe_pkg::retire_t          ex_retire;
    isa_pkg::decoded_t          id_decoded;

    logic                       id_valid;
    logic                       ex_valid;
    logic                       ex_allow_in;
    logic                       wb_allow_in;

    logic [`CPU_REG_ADDR_W-1:0] rs_addr;
    logic [`CPU_REG_ADDR_W-1:0] rt_addr;
    logic [`CPU_REG_ADDR_W-1:0] id_shamt;
    logic [`CPU_XLEN-1:0]       rs_rf;
    logic [`CPU_XLEN-1:0]       rt_rf;
    logic [`CPU_XLEN-1:0]       rs_fwd;
    logic [`CPU_XLEN-1:0]       rt_fwd;

    logic [`CPU_XLEN-1:0]       alu_a;
    logic [`CPU_XLEN-1:0]       alu_b;
    logic [`CPU_XLEN-1:0]       alu_result;
    logic                       rf_wen;

    assign if_in.instr = inst_data;

    pipeline_reg #(.payload_t(pipe_pkg::fetch_t)) i_if_id (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (inst_valid),
        .allow_out (ex_allow_in),
        .data_in   (if_in),
        .allow_in  (inst_ready),
        .valid_out (id_valid),
        .data_out  (id_fetch)
    );

    // ID stage
    decode_unit i_decode (
        .instr   (id_fetch.instr),
        .decoded (id_decoded),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .shamt   (id_shamt)
    );

    // written when the trace item is taken
    assign rf_wen = trace_valid && trace_ready && trace.wen;

    regfile i_regfile (
        .clk     (clk),
        .reset   (reset),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .wen     (rf_wen),
        .waddr   (trace.waddr),
        .wdata   (trace.wdata),
        .rs_data (rs_rf),
        .rt_data (rt_rf)
    );

    forward_select i_fwd_rs (
        .src_addr  (rs_addr),
        .rf_data   (rs_rf),
        .ex_valid  (ex_valid),
        .ex_result (ex_retire),
        .wb_valid  (trace_valid),
        .wb_result (trace),
        .operand   (rs_fwd)
    );

    forward_select i_fwd_rt (
        .src_addr  (rt_addr),
        .rf_data   (rt_rf),
        .ex_valid  (ex_valid),
        .ex_result (ex_retire),
        .wb_valid  (trace_valid),
        .wb_result (trace),
        .operand   (rt_fwd)
    );

    assign id_exec.dec     = id_decoded;
    assign id_exec.rs_data = rs_fwd;
    assign id_exec.rt_data = rt_fwd;
    assign id_exec.shamt   = id_shamt;

    pipeline_reg #(.payload_t(pipe_pkg::exec_t)) i_id_ex (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (id_valid),
        .allow_out (wb_allow_in),
        .data_in   (id_exec),
        .allow_in  (ex_allow_in),
        .valid_out (ex_valid),
        .data_out  (ex_exec)
    );

    // EX stage operand muxes
    assign alu_a = ex_exec.dec.use_shamt
                 ? {{(`CPU_XLEN-`CPU_REG_ADDR_W){1'b0}}, ex_exec.shamt}
                 : ex_exec.rs_data;
    assign alu_b = (ex_exec.dec.src_b == isa_pkg::SRC_B_IMM) ? ex_exec.dec.imm
                                                             : ex_exec.rt_data;

    alu i_alu (
        .op     (ex_exec.dec.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    assign ex_retire.wen   = ex_exec.dec.wen;
    assign ex_retire.waddr = ex_exec.dec.dest;
    assign ex_retire.wdata = alu_result;

    // WB register doubles as the trace port
    pipeline_reg #(.payload_t(pipe_pkg::retire_t)) i_ex_wb (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (ex_valid),
        .allow_out (trace_ready),
        .data_in   (ex_retire),
        .allow_in  (wb_allow_in),
        .valid_out (trace_valid),
        .data_out  (trace)
    );

endmodule

`default_nettype wire

//--- testbench/tb_alu_pipeline.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_macros.svh"

module tb_alu_pipeline;

    localparam int WAIT_LIMIT = 200;

    // expected trace item with the edge number of its acceptance
    typedef struct packed {
        pipe_pkg::retire_t item;
        int                cycle;
    } expect_t;

    logic                 clk;
    logic                 reset;
    logic                 inst_valid;
    logic [`CPU_XLEN-1:0] inst_data;
    logic                 trace_ready;
    logic                 inst_ready;
    logic                 trace_valid;
    pipe_pkg::retire_t    trace;

    logic [`CPU_XLEN-1:0] mregs [`CPU_REG_COUNT];
    expect_t              exp_q [$];
    pipe_pkg::retire_t    exp_head;
    logic                 head_valid = 1'b0;
    int                   head_cycle = 0;
    int                   cycle = 0;
    int                   last_stall = 0;
    int                   n_accepted = 0;
    int                   n_retired = 0;
    int                   mismatches = 0;
    int                   protocol_errors = 0;
    int                   timeouts = 0;
    int                   count_errors = 0;
    logic [31:0]          rng;
    logic                 random_ready;
    logic                 chain_mode;
    logic [4:0]           hist [2];
    string                test_name;

    alu_pipeline_top i_alu_pipeline_top (
        .clk         (clk),
        .reset       (reset),
        .inst_valid  (inst_valid),
        .inst_data   (inst_data),
        .trace_ready (trace_ready),
        .inst_ready  (inst_ready),
        .trace_valid (trace_valid),
        .trace       (trace)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // mostly registers 0 to 7 so dependences are dense
    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = next_rand();
        return (r[3:0] == 4'h0) ? r[8:4] : {2'b00, r[6:4]};
    endfunction

    function automatic logic [31:0] r_type(input logic [5:0] fn, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd,
                                           input logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] gen_instr();
        logic [31:0] r;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [5:0]  fn;
        logic [5:0]  op;
        logic [31:0] ins;
        r  = next_rand();
        // chain mode reads the last or second last result
        rs = chain_mode ? hist[r[5]] : pick_reg();
        rt = chain_mode ? hist[!r[5]] : pick_reg();
        rd = pick_reg();
        if (chain_mode && rd == 5'd0) begin
            rd = 5'd1;
        end
        case (r[13:10])
            4'd1:    fn = 6'h23;
            4'd2:    fn = 6'h24;
            4'd3:    fn = 6'h25;
            4'd4:    fn = 6'h26;
            4'd5:    fn = 6'h27;
            4'd6:    fn = 6'h2a;
            4'd7:    fn = 6'h2b;
            4'd8:    fn = 6'h00;
            4'd9:    fn = 6'h02;
            4'd10:   fn = 6'h03;
            default: fn = 6'h21;
        endcase
        // addiu through lui are opcodes 0x09 to 0x0f
        op = (r[16:14] == 3'd7) ? 6'h09 : 6'h09 + {3'b000, r[16:14]};
        if (r[9:6] >= 4'd14 && !chain_mode) begin
            // mult and lw are not supported
            ins = r[17] ? r_type(6'h18, rs, rt, rd, r[22:18]) : i_type(6'h23, rs, rd, r[31:16]);
        end else if (r[9:6] >= 4'd9) begin
            ins = i_type(op, rs, rd, r[31:16]);
        end else begin
            ins = r_type(fn, rs, rt, rd, r[22:18]);
        end
        hist[1] = hist[0];
        hist[0] = rd;
        return ins;
    endfunction

    // architectural result of one instruction, applied to the model registers
    function automatic pipe_pkg::retire_t model_exec(input logic [31:0] ins);
        pipe_pkg::retire_t res;
        logic [31:0]       s;
        logic [31:0]       t;
        logic [31:0]       se;
        logic [31:0]       ze;
        logic [31:0]       val;
        logic [4:0]        dest;
        logic              ok;
        s    = mregs[ins[25:21]];
        t    = mregs[ins[20:16]];
        se   = {{16{ins[15]}}, ins[15:0]};
        ze   = {16'h0000, ins[15:0]};
        dest = ins[20:16];
        ok   = 1'b1;
        val  = '0;
        case (ins[31:26])
            6'h00: begin
                dest = ins[15:11];
                case (ins[5:0])
                    6'h00:   val = t << ins[10:6];
                    6'h02:   val = t >> ins[10:6];
                    6'h03:   val = $signed(t) >>> ins[10:6];
                    6'h21:   val = s + t;
                    6'h23:   val = s - t;
                    6'h24:   val = s & t;
                    6'h25:   val = s | t;
                    6'h26:   val = s ^ t;
                    6'h27:   val = ~(s | t);
                    6'h2a:   val = {31'b0, $signed(s) < $signed(t)};
                    6'h2b:   val = {31'b0, s < t};
                    default: ok = 1'b0;
                endcase
            end
            6'h09:   val = s + se;
            6'h0a:   val = {31'b0, $signed(s) < $signed(se)};
            6'h0b:   val = {31'b0, s < se};
            6'h0c:   val = s & ze;
            6'h0d:   val = s | ze;
            6'h0e:   val = s ^ ze;
            6'h0f:   val = {ins[15:0], 16'h0000};
            default: ok = 1'b0;
        endcase
        res.wen   = ok && (dest != 5'd0);
        res.waddr = dest;
        res.wdata = val;
        if (res.wen) begin
            mregs[dest] = val;
        end
        return res;
    endfunction

    function automatic logic same_item(input pipe_pkg::retire_t got,
                                       input pipe_pkg::retire_t exp);
        return got.wen == exp.wen && got.waddr == exp.waddr
            && (!exp.wen || got.wdata == exp.wdata);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (random_ready) begin
            trace_ready = (next_rand() % 3) != 0;
        end
    endtask

    task automatic send_instr(input logic [31:0] instr);
        logic took;
        int   waited;
        took   = 1'b0;
        waited = 0;
        if (timeouts != 0) begin
            return;
        end
        if (random_ready && (next_rand() % 4) == 0) begin
            next_cycle();
        end
        inst_valid = 1'b1;
        inst_data  = instr;
        while (!took && waited < WAIT_LIMIT) begin
            @(negedge clk);
            took = inst_ready;
            next_cycle();
            waited++;
        end
        inst_valid = 1'b0;
        if (!took) begin
            timeouts++;
            $display("Timeout: instruction %h was never accepted (%s)", instr, test_name);
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (n_retired != n_accepted && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (n_retired != n_accepted) begin
            timeouts++;
            $display("Timeout: pipeline did not drain, %0d items missing",
                     n_accepted - n_retired);
        end
    endtask

    // reference model, expected head is registered for the assertions
    always @(posedge clk) begin
        expect_t entry;
        if (reset) begin
            exp_q.delete();
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                mregs[i] = '0;
            end
        end else begin
            if (trace_valid && trace_ready) begin
                n_retired++;
                if (exp_q.size() != 0) begin
                    void'(exp_q.pop_front());
                end
            end
            if (inst_valid && inst_ready) begin
                entry.item  = model_exec(inst_data);
                entry.cycle = cycle;
                exp_q.push_back(entry);
                n_accepted++;
            end
            if (!trace_ready) begin
                last_stall <= cycle;
            end
        end
        cycle      <= cycle + 1;
        head_valid <= exp_q.size() != 0;
        if (exp_q.size() != 0) begin
            exp_head   <= exp_q[0].item;
            head_cycle <= exp_q[0].cycle;
        end
    end

    a_reset_state: assert property (@(posedge clk) reset |=> !trace_valid && inst_ready)
        else begin
            protocol_errors++;
            $display("After reset trace_valid is not low or inst_ready is not high");
        end

    a_no_extra_item: assert property (@(posedge clk) disable iff (reset)
        trace_valid && trace_ready |-> head_valid)
        else begin
            protocol_errors++;
            $display("A trace item retired with no instruction outstanding (%s)", test_name);
        end

    a_item_match: assert property (@(posedge clk) disable iff (reset)
        trace_valid && trace_ready && head_valid |-> same_item(trace, exp_head))
        else begin
            mismatches++;
            $display("Mismatch %s: expected wen/reg/data %0b/%0d/%h, actual %0b/%0d/%h",
                     test_name, $sampled(exp_head.wen), $sampled(exp_head.waddr),
                     $sampled(exp_head.wdata), $sampled(trace.wen), $sampled(trace.waddr),
                     $sampled(trace.wdata));
        end

    a_hold_stalled: assert property (@(posedge clk) disable iff (reset)
        trace_valid && !trace_ready |=> trace_valid && $stable(trace))
        else begin
            protocol_errors++;
            $display("Trace item changed or vanished while stalled (%s)", test_name);
        end

    // no stall since acceptance means retirement three edges later
    a_latency: assert property (@(posedge clk) disable iff (reset)
        trace_valid && trace_ready && head_valid && last_stall <= head_cycle
        |-> cycle == head_cycle + 3)
        else begin
            mismatches++;
            $display("Mismatch latency (%s): expected edge %0d, actual edge %0d",
                     test_name, $sampled(head_cycle) + 3, $sampled(cycle));
        end

    initial begin
        reset        = 1'b1;
        inst_valid   = 1'b0;
        inst_data    = '0;
        trace_ready  = 1'b1;
        rng          = 32'd41058;
        random_ready = 1'b0;
        chain_mode   = 1'b0;
        hist[0]      = 5'd1;
        hist[1]      = 5'd2;
        test_name    = "reset";
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        test_name  = "dependent_chain";
        chain_mode = 1'b1;
        repeat (60) send_instr(gen_instr());

        test_name  = "zero_and_unknown";
        chain_mode = 1'b0;
        send_instr(i_type(6'h09, 5'd1, 5'd0, 16'h1234));
        send_instr(r_type(6'h21, 5'd3, 5'd4, 5'd0, 5'd0));
        send_instr(32'hfc00_0000);
        send_instr(r_type(6'h3f, 5'd1, 5'd2, 5'd3, 5'd0));
        send_instr(r_type(6'h25, 5'd0, 5'd0, 5'd5, 5'd0));
        send_instr(i_type(6'h0d, 5'd0, 5'd6, 16'h0000));

        test_name    = "random_backpressure";
        random_ready = 1'b1;
        repeat (250) send_instr(gen_instr());

        test_name    = "drain";
        random_ready = 1'b0;
        trace_ready  = 1'b1;
        drain();
        repeat (2) next_cycle();

        a_count_equal: assert (n_accepted == n_retired)
            else begin
                count_errors++;
                $display("Mismatch item_count: expected %0d, actual %0d", n_accepted, n_retired);
            end

        $display("Accepted %0d, retired %0d; mismatches %0d, protocol %0d, timeouts %0d, count %0d",
                 n_accepted, n_retired, mismatches, protocol_errors, timeouts, count_errors);
        if (mismatches + protocol_errors + timeouts + count_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/pipeline_reg.sv
logic/decode_unit.sv
logic/regfile.sv
logic/forward_select.sv
logic/alu.sv
logic/alu_pipeline_top.sv
testbench/tb_alu_pipeline.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_alu_pipeline \
    -Mdir obj_dir -o sim_tb

output=$(./obj_dir/sim_tb) || true
echo "$output"

if echo "$output" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1
